//--- Bender.yml
package:
  name: stream_read

sources:
  # Packages first, the request package uses the AXI package
  - design/axi_read_pkg.sv
  - design/stream_read_pkg.sv
  - design/burst_cmd_if.sv
  - design/read_beat_if.sv
  - design/sync_fifo.sv
  - design/stream_cmd_sequencer.sv
  - design/axi_burst_reader.sv
  - design/response_packer.sv
  - design/stream_read_top.sv
  - target: test
    files:
      - bench/stream_read_sva.sv
      - bench/stream_read_checker.sv
      - bench/tb_stream_read.sv

//--- bench/stream_read_checker.sv
// Predicts every response from accepted requests and the memory word rule
// Assumes one burst per request, issued in request order
`timescale 1ns/100ps
`default_nettype none

module stream_read_checker #(
  parameter logic [31:0] WORD_PATTERN = 32'h0
) (
  input logic                    ap_clk,
  input logic                    areset_control,
  input logic                    req_valid,
  input logic                    req_ready,
  input stream_read_pkg::addr_t  req_addr,
  input stream_read_pkg::beats_t req_beats,
  input stream_read_pkg::tag_t   req_tag,
  input logic                    resp_valid,
  input logic                    resp_ready,
  input axi_read_pkg::data_t     resp_data,
  input stream_read_pkg::tag_t   resp_tag,
  input logic                    resp_last,
  input logic                    done,
  input logic                    m_axi_arvalid,
  input logic                    m_axi_arready,
  input stream_read_pkg::addr_t  m_axi_araddr,
  input axi_read_pkg::axi_len_t  m_axi_arlen
);
  import stream_read_pkg::*;
  import axi_read_pkg::*;

  // Expected responses, oldest first
  data_t    exp_data [$];
  tag_t     exp_tag [$];
  logic     exp_last [$];
  // Expected address phases
  addr_t    exp_araddr [$];
  beats_t   exp_beats [$];

  integer error_count = 0;
  integer checked     = 0;
  integer outstanding = 0;
  integer rst_cycles  = 0;
  integer since_reset = 0;
  integer busy_age    = 0;
  integer quiet_age   = 0;

  // Slave memory: address XOR pattern in both halves
  function automatic data_t expected_word(input addr_t byte_addr);
    expected_word = {byte_addr ^ WORD_PATTERN, byte_addr ^ WORD_PATTERN};
  endfunction

  always @(posedge ap_clk) begin : compare
    integer k;
    if (areset_control) begin
      // First reset edge still shows the old done
      if (rst_cycles > 0 && done !== 1'b0) begin
        $display("[ERROR] %0t: done high during reset", $time);
        error_count++;
      end
      rst_cycles++;
      since_reset = 0;
      busy_age    = 0;
      quiet_age   = 0;
      exp_data.delete();
      exp_tag.delete();
      exp_last.delete();
      exp_araddr.delete();
      exp_beats.delete();
      outstanding = 0;
    end else begin
      rst_cycles = 0;
      // --------------------
      // done rules, one cycle of register lag allowed
      if (since_reset < 2 && done !== 1'b0) begin
        $display("[ERROR] %0t: done high right after reset", $time);
        error_count++;
      end
      if (busy_age >= 2 && done !== 1'b0) begin
        $display("[ERROR] %0t: done high with %0d beats pending", $time, outstanding);
        error_count++;
      end
      if (quiet_age >= 6 && done !== 1'b1) begin
        $display("[ERROR] %0t: done low after %0d quiet cycles", $time, quiet_age);
        error_count++;
      end
      since_reset++;
      // Accepted request expands into its beats
      if (req_valid && req_ready) begin
        for (k = 0; k < int'(req_beats); k++) begin
          exp_data.push_back(expected_word(req_addr + addr_t'(k * AXI_BYTES_PER_BEAT)));
          exp_tag.push_back(req_tag);
          exp_last.push_back(k == int'(req_beats) - 1);
        end
        exp_araddr.push_back(req_addr);
        exp_beats.push_back(req_beats);
      end
      // --------------------
      // Address phase, arlen counts beats after the first
      if (m_axi_arvalid && m_axi_arready) begin
        if (exp_araddr.size() == 0) begin
          $display("[ERROR] %0t: address phase with no request queued", $time);
          error_count++;
        end else begin
          if (m_axi_araddr !== exp_araddr[0] ||
              {1'b0, m_axi_arlen} + 9'd1 !== {1'b0, exp_beats[0]}) begin
            $display("[ERROR] %0t: araddr expected %h for %0d beats, got %h arlen %0d",
                     $time, exp_araddr[0], exp_beats[0], m_axi_araddr, m_axi_arlen);
            error_count++;
          end
          void'(exp_araddr.pop_front());
          void'(exp_beats.pop_front());
        end
      end
      // Client response
      if (resp_valid && resp_ready) begin
        if (exp_data.size() == 0) begin
          $display("[ERROR] %0t: response with no beat expected", $time);
          error_count++;
        end else begin
          if (resp_data !== exp_data[0] || resp_tag !== exp_tag[0] ||
              resp_last !== exp_last[0]) begin
            $display("[ERROR] %0t: expected %h tag %0d last %b, got %h tag %0d last %b",
                     $time, exp_data[0], exp_tag[0], exp_last[0],
                     resp_data, resp_tag, resp_last);
            error_count++;
          end
          void'(exp_data.pop_front());
          void'(exp_tag.pop_front());
          void'(exp_last.pop_front());
          checked++;
        end
      end
      outstanding = exp_data.size();
      busy_age    = (outstanding != 0) ? busy_age + 1 : 0;
      quiet_age   = (outstanding == 0 && !req_valid) ? quiet_age + 1 : 0;
    end
  end

endmodule

`default_nettype wire

//--- bench/stream_read_sva.sv
// Handshake rules on the AXI read port and the client response port
// Bound into stream_read_top; the burst window opens when arvalid rises
`timescale 1ns/100ps
`default_nettype none

module stream_read_sva (
  input logic                   ap_clk,
  input logic                   areset_control,
  input logic                   m_axi_arvalid,
  input logic                   m_axi_arready,
  input stream_read_pkg::addr_t m_axi_araddr,
  input axi_read_pkg::axi_len_t m_axi_arlen,
  input logic                   m_axi_rvalid,
  input logic                   m_axi_rready,
  input logic                   m_axi_rlast,
  input logic                   resp_valid,
  input logic                   resp_ready,
  input axi_read_pkg::data_t    resp_data,
  input stream_read_pkg::tag_t  resp_tag,
  input logic                   resp_last
);

  // Failed assertions so far
  integer fail_count = 0;
  logic   r_window;

  // Open from arvalid up to the rlast beat
  always @(posedge ap_clk) begin
    if (areset_control) r_window <= 1'b0;
    else if (m_axi_rvalid && m_axi_rready && m_axi_rlast) r_window <= 1'b0;
    else if (m_axi_arvalid) r_window <= 1'b1;
  end

  // --------------------
  ar_hold_a: assert property (@(posedge ap_clk) disable iff (areset_control)
    m_axi_arvalid && !m_axi_arready |=>
      m_axi_arvalid && $stable(m_axi_araddr) && $stable(m_axi_arlen))
    else begin
      $error("arvalid dropped or address changed before arready");
      fail_count++;
    end

  // Response head holds until the client takes it
  resp_hold_a: assert property (@(posedge ap_clk) disable iff (areset_control)
    resp_valid && !resp_ready |=>
      resp_valid && $stable(resp_data) && $stable(resp_tag) && $stable(resp_last))
    else begin
      $error("response changed or vanished before resp_ready");
      fail_count++;
    end

  rready_window_a: assert property (@(posedge ap_clk) disable iff (areset_control)
    m_axi_rready |-> (m_axi_arvalid || r_window))
    else begin
      $error("rready high outside a burst");
      fail_count++;
    end

endmodule

`default_nettype wire

//--- bench/tb_stream_read.sv
// Random traffic against a behavioral AXI4 read slave, one burst served at a time
// Slave memory word depends on the whole byte address; seed is fixed
`timescale 1ns/100ps
`default_nettype none

module tb_stream_read;
  import stream_read_pkg::*;
  import axi_read_pkg::*;

  localparam logic [31:0] WORD_PATTERN = 32'hc3a5_5a3c;
  localparam int          MAX_BEATS    = 16;

  logic     ap_clk;
  logic     areset_control;
  logic     req_valid;
  logic     req_ready;
  addr_t    req_addr;
  beats_t   req_beats;
  tag_t     req_tag;
  logic     resp_valid;
  logic     resp_ready;
  data_t    resp_data;
  tag_t     resp_tag;
  logic     resp_last;
  logic     done;
  logic     m_axi_arvalid;
  logic     m_axi_arready;
  addr_t    m_axi_araddr;
  axi_len_t m_axi_arlen;
  logic     m_axi_rvalid;
  logic     m_axi_rready;
  data_t    m_axi_rdata;
  logic     m_axi_rlast;

  // One random stream per process
  integer seed;
  integer slave_seed;
  integer drain_seed;
  // Run bookkeeping
  integer total_beats  = 0;
  integer tests_run    = 0;
  integer tests_failed = 0;
  integer tb_errors    = 0;
  integer errors_seen  = 0;
  // Slave and client knobs
  integer max_delay    = 2;
  logic   ar_block     = 1'b0;
  logic   bp_on        = 1'b0;
  logic   full_seen    = 1'b0;
  logic   stall_seen   = 1'b0;
  tag_t   next_tag     = '0;

  stream_read_top stream_read_top_i (
    .ap_clk(ap_clk), .areset_control(areset_control),
    .req_valid(req_valid), .req_ready(req_ready), .req_addr(req_addr),
    .req_beats(req_beats), .req_tag(req_tag),
    .resp_valid(resp_valid), .resp_ready(resp_ready), .resp_data(resp_data),
    .resp_tag(resp_tag), .resp_last(resp_last), .done(done),
    .m_axi_arvalid(m_axi_arvalid), .m_axi_arready(m_axi_arready),
    .m_axi_araddr(m_axi_araddr), .m_axi_arlen(m_axi_arlen),
    .m_axi_rvalid(m_axi_rvalid), .m_axi_rready(m_axi_rready),
    .m_axi_rdata(m_axi_rdata), .m_axi_rlast(m_axi_rlast)
  );

  stream_read_checker #(.WORD_PATTERN(WORD_PATTERN)) checker_i (.*);

  bind stream_read_top stream_read_sva stream_read_sva_i (.*);

  initial begin : clock_gen
    ap_clk = 1'b0;
    forever #5 ap_clk = ~ap_clk;
  end

  // --------------------
  function automatic addr_t random_addr();
    random_addr = addr_t'($random(seed)) & ~addr_t'(AXI_BYTES_PER_BEAT - 1);
  endfunction

  function automatic beats_t random_beats();
    random_beats = beats_t'(1 + ($unsigned($random(seed)) % MAX_BEATS));
  endfunction

  function automatic data_t mem_word(input addr_t byte_addr);
    mem_word = {byte_addr ^ WORD_PATTERN, byte_addr ^ WORD_PATTERN};
  endfunction

  function automatic integer error_total();
    error_total = tb_errors + checker_i.error_count +
                  stream_read_top_i.stream_read_sva_i.fail_count;
  endfunction

  // Leaves the caller 1 ns after a rising edge
  task automatic idle_cycles(input integer n);
    repeat (n) begin
      @(posedge ap_clk);
      #1;
    end
  endtask

  task automatic apply_reset();
    areset_control = 1'b1;
    idle_cycles(10);
    areset_control = 1'b0;
  endtask

  task automatic push_request(input addr_t addr, input beats_t beats);
    req_valid = 1'b1;
    req_addr  = addr;
    req_beats = beats;
    req_tag   = next_tag;
    // req_ready only moves on clock edges
    do begin
      @(negedge ap_clk);
      if (!req_ready) full_seen = 1'b1;
    end while (!req_ready);
    @(posedge ap_clk);
    #1;
    req_valid   = 1'b0;
    next_tag    = next_tag + 1'b1;
    total_beats = total_beats + int'(beats);
  endtask

  task automatic wait_drained();
    do @(negedge ap_clk); while (checker_i.outstanding != 0 || done !== 1'b1);
    @(posedge ap_clk);
    #1;
  endtask

  task automatic finish_test(input string name);
    integer now_errors;
    now_errors = error_total();
    tests_run++;
    if (now_errors != errors_seen) begin
      tests_failed++;
      $display("test %0d %s: failed, %0d errors", tests_run, name, now_errors - errors_seen);
    end else begin
      $display("test %0d %s: ok", tests_run, name);
    end
    errors_seen = now_errors;
  endtask

  // --------------------
  // AXI slave, address phase then all beats of the burst
  initial begin : axi_slave
    addr_t  base;
    integer len;
    integer k;
    m_axi_arready = 1'b0;
    m_axi_rvalid  = 1'b0;
    m_axi_rdata   = '0;
    m_axi_rlast   = 1'b0;
    forever begin
      idle_cycles(1);
      if (m_axi_arvalid && !ar_block) begin
        idle_cycles($unsigned($random(slave_seed)) % (max_delay + 1));
        base          = m_axi_araddr;
        len           = int'(m_axi_arlen);
        m_axi_arready = 1'b1;
        idle_cycles(1);
        m_axi_arready = 1'b0;
        for (k = 0; k <= len; k++) begin
          m_axi_rvalid = 1'b0;
          m_axi_rlast  = 1'b0;
          idle_cycles($unsigned($random(slave_seed)) % (max_delay + 1));
          m_axi_rvalid = 1'b1;
          m_axi_rdata  = mem_word(base + addr_t'(k * AXI_BYTES_PER_BEAT));
          m_axi_rlast  = (k == len);
          // Low rready here means the response queue is backed up
          do begin
            @(negedge ap_clk);
            if (!m_axi_rready) stall_seen = 1'b1;
          end while (!m_axi_rready);
          idle_cycles(1);
        end
        m_axi_rvalid = 1'b0;
        m_axi_rlast  = 1'b0;
      end
    end
  end

  // Client side of the response queue, ready 1 in 8 cycles under back-pressure
  initial begin : client_drain
    resp_ready = 1'b1;
    forever begin
      idle_cycles(1);
      resp_ready = bp_on ? (($unsigned($random(drain_seed)) % 8) == 0) : 1'b1;
    end
  end

  // Limit grows with every requested beat
  initial begin : watchdog
    integer cycles;
    cycles = 0;
    while (cycles <= 40 * total_beats + 2000) begin
      @(posedge ap_clk);
      cycles++;
    end
    $display("Timeout: run did not finish within %0d cycles", cycles);
    $display("** FAIL **");
    $finish;
  end

  initial begin : stimulus
    integer i;
    seed       = 7524;
    slave_seed = $random(seed);
    drain_seed = $random(seed);
    req_valid  = 1'b0;
    req_addr   = '0;
    req_beats  = beats_t'(1);
    req_tag    = '0;
    apply_reset();

    for (i = 0; i < 6; i++) begin
      push_request(random_addr(), random_beats());
      wait_drained();
      idle_cycles(4);
    end
    finish_test("single requests with idle gaps");

    // Slave holds the first burst so the request queue fills
    ar_block  = 1'b1;
    full_seen = 1'b0;
    fork
      for (i = 0; i < REQ_DEPTH + 4; i++) push_request(random_addr(), random_beats());
      begin
        idle_cycles(4 * REQ_DEPTH + 20);
        ar_block = 1'b0;
      end
    join
    wait_drained();
    if (!full_seen) begin
      $display("req_ready never fell while the request queue was full");
      tb_errors++;
    end
    finish_test("back-to-back requests");

    // Slow client fills the response queue until rready drops
    stall_seen = 1'b0;
    bp_on      = 1'b1;
    for (i = 0; i < 10; i++) push_request(random_addr(), random_beats());
    wait_drained();
    bp_on = 1'b0;
    if (!stall_seen) begin
      $display("rready never fell while the response queue was backed up");
      tb_errors++;
    end
    finish_test("response back-pressure");

    max_delay = 6;
    for (i = 0; i < 10; i++) push_request(random_addr(), random_beats());
    wait_drained();
    max_delay = 2;
    finish_test("slave delays");

    push_request(random_addr(), random_beats());
    idle_cycles(2);
    if (done !== 1'b0) begin
      $display("[ERROR] %0t: done stayed high with a request pending", $time);
      tb_errors++;
    end
    wait_drained();
    idle_cycles(5);
    if (done !== 1'b1) begin
      $display("[ERROR] %0t: done not high after the unit drained", $time);
      tb_errors++;
    end
    apply_reset();
    if (done !== 1'b0) begin
      $display("[ERROR] %0t: done high right after reset", $time);
      tb_errors++;
    end
    wait_drained();
    finish_test("done flag");

    $display("tests run %0d, failed %0d, responses checked %0d, errors %0d",
             tests_run, tests_failed, checker_i.checked, error_total());
    if (tests_failed == 0 && error_total() == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- design/axi_burst_reader.sv
// AXI4 read master for one INCR burst at a time
// Address is aligned down to the bus width; rready only inside a burst
`timescale 1ns/100ps
`default_nettype none

module axi_burst_reader (
  input  logic                   ap_clk,
  input  logic                   areset_control,
  // AXI read address channel
  input  logic                   m_axi_arready,
  output logic                   m_axi_arvalid,
  output stream_read_pkg::addr_t m_axi_araddr,
  output axi_read_pkg::axi_len_t m_axi_arlen,
  // AXI read data channel
  input  logic                   m_axi_rvalid,
  input  axi_read_pkg::data_t    m_axi_rdata,
  input  logic                   m_axi_rlast,
  output logic                   m_axi_rready,
  burst_cmd_if.reader            cmd,
  read_beat_if.reader            beat
);
  import stream_read_pkg::*;
  import axi_read_pkg::*;

  // Clears the byte offset inside one beat
  localparam addr_t ALIGN_MASK = ~addr_t'(AXI_BYTES_PER_BEAT - 1);

  logic in_burst;
  logic r_fire;

  assign r_fire = m_axi_rvalid & m_axi_rready;

  // --------------------
  // Address phase
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      m_axi_arvalid <= 1'b0;
    end else if (cmd.start) begin
      m_axi_arvalid <= 1'b1;
    end else if (m_axi_arready) begin
      // Held until the slave takes it
      m_axi_arvalid <= 1'b0;
    end
  end

  // Address and length latched with start
  always_ff @(posedge ap_clk) begin
    if (cmd.start) begin
      m_axi_araddr <= cmd.addr & ALIGN_MASK;
      // arlen is beats minus one
      m_axi_arlen  <= axi_len_t'(cmd.beats - 1'b1);
    end
  end

  // --------------------
  // Data phase
  // Burst window runs from start to the rlast beat
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      in_burst <= 1'b0;
    end else if (cmd.start) begin
      in_burst <= 1'b1;
    end else if (r_fire && m_axi_rlast) begin
      in_burst <= 1'b0;
    end
  end

  // Beats pass straight through to the packer
  assign beat.valid   = m_axi_rvalid & in_burst;
  assign beat.data    = m_axi_rdata;
  assign beat.last    = m_axi_rlast;

  // Packer back-pressure reaches the slave here
  assign m_axi_rready = beat.ready & in_burst;

endmodule

`default_nettype wire

//--- design/axi_read_pkg.sv
// AXI4 read channel widths for a 64-bit data bus
// Bursts are always INCR at full bus width
`default_nettype none

package axi_read_pkg;

  // --------------------
  // Channel widths
  localparam int AXI_DATA_W = 64;
  localparam int AXI_LEN_W  = 8;

  typedef logic [AXI_DATA_W-1:0] data_t;
  typedef logic [AXI_LEN_W-1:0]  axi_len_t;

  // --------------------
  // Fixed burst attributes
  localparam logic [2:0] AXI_SIZE_FULL  = 3'd3;
  localparam logic [1:0] AXI_BURST_INCR = 2'd1;

  // Address step between beats
  localparam int AXI_BYTES_PER_BEAT = 1 << AXI_SIZE_FULL;

endpackage

`default_nettype wire

//--- design/burst_cmd_if.sv
// One burst command in flight at a time
// Fields stay stable from start until done
`timescale 1ns/100ps
`default_nettype none

interface burst_cmd_if;
  import stream_read_pkg::*;

  // One-cycle pulses
  logic   start;
  logic   done;
  // Command fields from the request queue head
  addr_t  addr;
  beats_t beats;
  tag_t   tag;

  modport sequencer (output start, output addr, output beats, output tag, input done);
  modport reader    (input start, input addr, input beats);
  modport packer    (input start, input beats, input tag, output done);

endinterface

`default_nettype wire

//--- design/read_beat_if.sv
// Read data beats, valid/ready handshake
`timescale 1ns/100ps
`default_nettype none

interface read_beat_if;
  import axi_read_pkg::*;

  // Transfer when valid and ready are both high
  logic  valid;
  logic  ready;
  data_t data;
  // Copy of rlast
  logic  last;

  // Reader is the source
  modport reader (output valid, output data, output last, input ready);
  // Packer is the sink
  modport packer (input valid, input data, input last, output ready);

endinterface

`default_nettype wire

//--- design/response_packer.sv
// Tags each returning beat and queues it for the client
// Stops taking beats when fewer than RESP_ALMOST_FULL entries are free
`timescale 1ns/100ps
`default_nettype none

module response_packer (
  input  logic                  ap_clk,
  input  logic                  areset_control,
  input  logic                  idle,
  input  logic                  resp_ready,
  output logic                  resp_valid,
  output axi_read_pkg::data_t   resp_data,
  output stream_read_pkg::tag_t resp_tag,
  output logic                  resp_last,
  output logic                  done,
  burst_cmd_if.packer           cmd,
  read_beat_if.packer           beat
);
  import stream_read_pkg::*;

  beats_t remaining;
  tag_t   tag_q;
  logic   busy;
  logic   beat_fire;
  logic   final_beat;
  logic   burst_end;
  logic   done_pulse;
  resp_t  wr_entry;
  resp_t  rd_entry;
  logic   q_empty;
  logic   q_almost_full;

  assign beat_fire  = beat.valid & beat.ready;
  assign final_beat = (remaining == beats_t'(1));
  // Early rlast also closes the burst so the sequencer never hangs
  assign burst_end  = beat_fire & (final_beat | beat.last);

  // --------------------
  // Beat counter
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      remaining  <= '0;
      busy       <= 1'b0;
      done_pulse <= 1'b0;
    end else begin
      done_pulse <= burst_end;
      if (cmd.start) begin
        remaining <= cmd.beats;
        busy      <= 1'b1;
      end else if (beat_fire) begin
        remaining <= remaining - 1'b1;
        if (burst_end) busy <= 1'b0;
      end
    end
  end

  // Tag of the burst in flight
  always_ff @(posedge ap_clk) begin
    if (cmd.start) tag_q <= cmd.tag;
  end

  assign cmd.done   = done_pulse;
  assign beat.ready = busy & ~q_almost_full;

  // --------------------
  // Response queue
  assign wr_entry = '{data: beat.data, tag: tag_q, last: final_beat | beat.last};

  sync_fifo #(
    .DEPTH             (RESP_DEPTH),
    .WIDTH             ($bits(resp_t)),
    .ALMOST_FULL_MARGIN(RESP_ALMOST_FULL)
  ) resp_queue_i (
    .ap_clk        (ap_clk),
    .areset_control(areset_control),
    .wr_en         (beat_fire),
    .din           (wr_entry),
    .rd_en         (resp_ready),
    .dout          (rd_entry),
    .full          (),
    .empty         (q_empty),
    .almost_full   (q_almost_full)
  );

  assign resp_valid = ~q_empty;
  assign resp_data  = rd_entry.data;
  assign resp_tag   = rd_entry.tag;
  assign resp_last  = rd_entry.last;

  // Both queues drained and sequencer idle
  always_ff @(posedge ap_clk) begin
    if (areset_control) done <= 1'b0;
    else done <= idle & q_empty;
  end

endmodule

`default_nettype wire

//--- design/stream_cmd_sequencer.sv
// Issues one burst per queued request and waits for its done pulse
// Requests leave the queue only after their burst completes
`timescale 1ns/100ps
`default_nettype none

module stream_cmd_sequencer (
  input  logic                  ap_clk,
  input  logic                  areset_control,
  input  logic                  req_valid,
  input  stream_read_pkg::req_t req_data,
  output logic                  req_ready,
  output logic                  idle,
  burst_cmd_if.sequencer        cmd
);
  import stream_read_pkg::*;

  req_t       head;
  logic       q_full;
  logic       q_empty;
  logic       q_pop;
  seq_state_e state;
  seq_state_e state_next;

  // --------------------
  // Request queue
  sync_fifo #(
    .DEPTH             (REQ_DEPTH),
    .WIDTH             ($bits(req_t)),
    .ALMOST_FULL_MARGIN(1)
  ) req_queue_i (
    .ap_clk        (ap_clk),
    .areset_control(areset_control),
    .wr_en         (req_valid),
    .din           (req_data),
    .rd_en         (q_pop),
    .dout          (head),
    .full          (q_full),
    .empty         (q_empty),
    .almost_full   ()
  );

  assign req_ready = ~q_full;

  // --------------------
  // State machine
  always_ff @(posedge ap_clk) begin
    if (areset_control) state <= RESET;
    else state <= state_next;
  end

  always_comb begin
    state_next = state;
    case (state)
      RESET:   state_next = READY;
      // Head visible, start a burst for it
      READY:   if (!q_empty) state_next = ISSUE;
      ISSUE:   state_next = PENDING;
      // Packer has tagged the last beat
      PENDING: if (cmd.done) state_next = DONE;
      DONE:    state_next = READY;
      default: state_next = RESET;
    endcase
  end

  // Start pulse for the single ISSUE cycle
  assign cmd.start = (state == ISSUE);
  // Head stays put until DONE, so fields are stable
  assign cmd.addr  = head.addr;
  assign cmd.beats = head.beats;
  assign cmd.tag   = head.tag;

  // Pop finished request
  assign q_pop = (state == DONE);
  assign idle  = (state == READY) & q_empty;

endmodule

`default_nettype wire

//--- design/stream_read_pkg.sv
// Request and response formats of the stream read unit
// Needs axi_read_pkg compiled first; a beat count of zero is illegal
`default_nettype none

package stream_read_pkg;

  // --------------------
  // Field widths
  localparam int ADDR_W  = 32;
  localparam int BEATS_W = 8;
  localparam int TAG_W   = 6;

  typedef logic [ADDR_W-1:0]  addr_t;
  typedef logic [BEATS_W-1:0] beats_t;
  typedef logic [TAG_W-1:0]   tag_t;

  // Request queue entry
  typedef struct packed {
    addr_t  addr;
    beats_t beats;
    tag_t   tag;
  } req_t;

  // Response queue entry, one per data beat
  typedef struct packed {
    axi_read_pkg::data_t data;
    tag_t                tag;
    logic                last;
  } resp_t;

  // --------------------
  // Queue sizing
  localparam int REQ_DEPTH        = 8;
  localparam int RESP_DEPTH       = 32;
  localparam int RESP_ALMOST_FULL = 4;

  // Command sequencer states
  typedef enum logic [2:0] {
    RESET,
    READY,
    ISSUE,
    PENDING,
    DONE
  } seq_state_e;

endpackage

`default_nettype wire

//--- design/stream_read_top.sv
// Stream read unit with one outstanding AXI4 read burst
// Fixed arsize (full width) and arburst (INCR); no rresp check
`timescale 1ns/100ps
`default_nettype none

module stream_read_top (
  input  logic                   ap_clk,
  input  logic                   areset_control,
  // Client requests
  input  logic                   req_valid,
  output logic                   req_ready,
  input  stream_read_pkg::addr_t req_addr,
  input  stream_read_pkg::beats_t req_beats,
  input  stream_read_pkg::tag_t  req_tag,
  // Client responses
  output logic                   resp_valid,
  input  logic                   resp_ready,
  output axi_read_pkg::data_t    resp_data,
  output stream_read_pkg::tag_t  resp_tag,
  output logic                   resp_last,
  output logic                   done,
  // AXI4 read master
  output logic                   m_axi_arvalid,
  input  logic                   m_axi_arready,
  output stream_read_pkg::addr_t m_axi_araddr,
  output axi_read_pkg::axi_len_t m_axi_arlen,
  input  logic                   m_axi_rvalid,
  output logic                   m_axi_rready,
  input  axi_read_pkg::data_t    m_axi_rdata,
  input  logic                   m_axi_rlast
);

  logic seq_idle;

  burst_cmd_if cmd_if ();
  read_beat_if beat_if ();

  // --------------------
  // Request side
  stream_cmd_sequencer stream_cmd_sequencer_i (
    .ap_clk        (ap_clk),
    .areset_control(areset_control),
    .req_valid     (req_valid),
    // Packed in req_t field order
    .req_data      ({req_addr, req_beats, req_tag}),
    .req_ready     (req_ready),
    .idle          (seq_idle),
    .cmd           (cmd_if.sequencer)
  );

  // AXI side
  axi_burst_reader axi_burst_reader_i (
    .ap_clk        (ap_clk),
    .areset_control(areset_control),
    .m_axi_arready (m_axi_arready),
    .m_axi_arvalid (m_axi_arvalid),
    .m_axi_araddr  (m_axi_araddr),
    .m_axi_arlen   (m_axi_arlen),
    .m_axi_rvalid  (m_axi_rvalid),
    .m_axi_rdata   (m_axi_rdata),
    .m_axi_rlast   (m_axi_rlast),
    .m_axi_rready  (m_axi_rready),
    .cmd           (cmd_if.reader),
    .beat          (beat_if.reader)
  );

  // Response side and done flag
  response_packer response_packer_i (
    .ap_clk        (ap_clk),
    .areset_control(areset_control),
    .idle          (seq_idle),
    .resp_ready    (resp_ready),
    .resp_valid    (resp_valid),
    .resp_data     (resp_data),
    .resp_tag      (resp_tag),
    .resp_last     (resp_last),
    .done          (done),
    .cmd           (cmd_if.packer),
    .beat          (beat_if.packer)
  );

endmodule

`default_nettype wire

//--- design/sync_fifo.sv
// First-word-fall-through FIFO; writes when full and reads when empty are ignored
`timescale 1ns/100ps
`default_nettype none

module sync_fifo #(
  parameter int DEPTH              = 8,
  parameter int WIDTH              = 8,
  parameter int ALMOST_FULL_MARGIN = 1
) (
  input  logic             ap_clk,
  input  logic             areset_control,
  input  logic             wr_en,
  input  logic [WIDTH-1:0] din,
  input  logic             rd_en,
  output logic [WIDTH-1:0] dout,
  output logic             full,
  output logic             empty,
  output logic             almost_full
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             push;
  logic             pop;

  // Pointer step with wrap at DEPTH
  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
    ptr_next = (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign push = wr_en & ~full;
  assign pop  = rd_en & ~empty;

  // --------------------
  // Pointers and occupancy
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= ptr_next(wr_ptr);
      if (pop)  rd_ptr <= ptr_next(rd_ptr);
      // Simultaneous push and pop leaves count alone
      if (push && !pop) count <= count + 1'b1;
      else if (pop && !push) count <= count - 1'b1;
    end
  end

  // Storage
  always_ff @(posedge ap_clk) begin
    if (push) mem[wr_ptr] <= din;
  end

  // Head word shows while not empty
  assign dout        = mem[rd_ptr];
  assign full        = (count == CNT_W'(DEPTH));
  assign empty       = (count == '0);
  // Fewer than ALMOST_FULL_MARGIN entries free
  assign almost_full = (count > CNT_W'(DEPTH - ALMOST_FULL_MARGIN));

endmodule

`default_nettype wire

//--- vlog.f
design/axi_read_pkg.sv
design/stream_read_pkg.sv
design/burst_cmd_if.sv
design/read_beat_if.sv
design/sync_fifo.sv
design/stream_cmd_sequencer.sv
design/axi_burst_reader.sv
design/response_packer.sv
design/stream_read_top.sv
bench/stream_read_sva.sv
bench/stream_read_checker.sv
bench/tb_stream_read.sv
